// ==== design/sifh_params.svh ====
`ifndef SIFH_PARAMS_SVH
`define SIFH_PARAMS_SVH

// time code width from the TDC
`define SIFH_NP 10

// upper code bits used as bin index, 32 bins
`define SIFH_BIN_BITS 5

// 4 pixels per frame
`define SIFH_PIXEL_BITS 2

// samples per pixel per frame
`define SIFH_ACQ_NUM 16

// saturating counter width, max 15
`define SIFH_COUNT_BITS 4

// ram address is pixel above bin
`define SIFH_ADDR_BITS (`SIFH_PIXEL_BITS + `SIFH_BIN_BITS)

`endif

// ==== design/sifhCtrlPkg.sv ====
package sifhCtrlPkg;

    // accumulator phase
    // ACCUMULATE takes samples, DRAIN empties the rmw pipe,
    // SCAN hands the ram to the peak scanner
    typedef enum logic [1:0] {
        ACCUMULATE,
        DRAIN,
        SCAN
    } accPhaseT;

    // peak scanner state
    // READ walks the addresses, FLUSH waits for the last data
    typedef enum logic [1:0] {
        IDLE,
        READ,
        FLUSH
    } scanStateT;

endpackage

// ==== design/sifhDataPkg.sv ====
`include "sifh_params.svh"

package sifhDataPkg;

    // raw time code
    typedef logic [`SIFH_NP-1:0] sampleT;

    // histogram bin index
    typedef logic [`SIFH_BIN_BITS-1:0] binT;

    // pixel index
    typedef logic [`SIFH_PIXEL_BITS-1:0] pixelT;

    // {pixel, bin}
    typedef logic [`SIFH_ADDR_BITS-1:0] ramAddrT;

    // per-bin count, saturates at all ones
    typedef logic [`SIFH_COUNT_BITS-1:0] countT;

    // one result per pixel, 11 bits
    typedef struct packed {
        pixelT pixel;
        binT   bin;
        countT count;
    } peakResultT;

endpackage

// ==== design/sifh_ifs.sv ====
`timescale 1ns/1ps

// front end to accumulator, one update per accepted sample
interface sifhBinUpdateIf;
    logic               valid;
    sifhDataPkg::pixelT pixel;
    sifhDataPkg::binT   bin;
    // high with the final valid of the frame
    logic               lastOfFrame;
    // level, same as top wrEn
    logic               accepting;

    modport frontEnd (
        output valid, pixel, bin, lastOfFrame,
        input  accepting
    );

    modport accumulator (
        input  valid, pixel, bin, lastOfFrame,
        output accepting
    );
endinterface

// accumulator to peak scanner, ram read access during scan
interface sifhScanIf;
    logic                 start;
    logic                 rdEn;
    sifhDataPkg::ramAddrT addr;
    // valid one cycle after rdEn
    sifhDataPkg::countT   rdData;
    logic                 done;

    modport accumulator (
        output start, rdData,
        input  rdEn, addr, done
    );

    modport scanner (
        input  start, rdData,
        output rdEn, addr, done
    );
endinterface

// ==== design/sifhSampleFrontEnd.sv ====
`timescale 1ns/1ps
`include "sifh_params.svh"

module sifhSampleFrontEnd (
    input  logic                clk,
    input  logic                rstN,
    input  logic                sampleValid,
    input  sifhDataPkg::sampleT sample,
    sifhBinUpdateIf.frontEnd    upd
);

    localparam int ACQ_BITS = $clog2(`SIFH_ACQ_NUM);

    logic                accept;
    logic [ACQ_BITS-1:0] acqCnt;
    sifhDataPkg::pixelT  pixelCnt;
    logic                lastAcq;
    logic                lastPixel;

    // sample only counts while the accumulator takes it
    assign accept    = sampleValid && upd.accepting;
    assign lastAcq   = (acqCnt == ACQ_BITS'(`SIFH_ACQ_NUM - 1));
    assign lastPixel = &pixelCnt;

    // strobes and counters
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            upd.valid       <= 1'b0;
            upd.lastOfFrame <= 1'b0;
            acqCnt          <= '0;
            pixelCnt        <= '0;
        end else begin
            upd.valid       <= accept;
            upd.lastOfFrame <= accept && lastAcq && lastPixel;
            if (accept) begin
                if (lastAcq) begin
                    acqCnt <= '0;
                    // frame end wraps pixel back to 0
                    if (lastPixel) begin
                        pixelCnt <= '0;
                    end else begin
                        pixelCnt <= pixelCnt + 1'b1;
                    end
                end else begin
                    acqCnt <= acqCnt + 1'b1;
                end
            end
        end
    end

    // payload, bin is the code msbs
    always_ff @(posedge clk) begin
        if (accept) begin
            upd.pixel <= pixelCnt;
            upd.bin   <= sample[`SIFH_NP-1 -: `SIFH_BIN_BITS];
        end
    end

endmodule

// ==== design/sifhHistRam.sv ====
`timescale 1ns/1ps

module sifhHistRam (
    input  logic                 clk,
    input  logic                 wrEn,
    input  sifhDataPkg::ramAddrT wrAddr,
    input  sifhDataPkg::countT   wrData,
    input  logic                 rdEn,
    input  sifhDataPkg::ramAddrT rdAddr,
    output sifhDataPkg::countT   rdData
);

    localparam int DEPTH = 2 ** $bits(sifhDataPkg::ramAddrT);

    sifhDataPkg::countT mem [DEPTH];

    // first frame starts from an empty histogram
    initial begin
        for (int i = 0; i < DEPTH; i++) begin
            mem[i] = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (wrEn) begin
            mem[wrAddr] <= wrData;
        end
    end

    // registered read, old data on same-cycle write
    always_ff @(posedge clk) begin
        if (rdEn) begin
            rdData <= mem[rdAddr];
        end
    end

endmodule

// ==== design/sifhHistAccumulator.sv ====
`timescale 1ns/1ps

module sifhHistAccumulator (
    input  logic                clk,
    input  logic                rstN,
    sifhBinUpdateIf.accumulator upd,
    sifhScanIf.accumulator      scan,
    output logic                wrEn
);

    sifhCtrlPkg::accPhaseT phase;
    logic                  drainCnt;
    logic                  inScan;

    // ram ports
    logic                  ramWrEn;
    sifhDataPkg::ramAddrT  ramWrAddr;
    sifhDataPkg::countT    ramWrData;
    logic                  ramRdEn;
    sifhDataPkg::ramAddrT  ramRdAddr;
    sifhDataPkg::countT    ramRdData;

    // rmw stage 2
    logic                  s1Valid;
    sifhDataPkg::ramAddrT  s1Addr;
    sifhDataPkg::countT    oldCount;
    sifhDataPkg::countT    incCount;

    // copy of last ram write, for forwarding
    logic                  fwdValid;
    sifhDataPkg::ramAddrT  fwdAddr;
    sifhDataPkg::countT    fwdData;

    // clear-behind during scan
    logic                  clrValid;
    sifhDataPkg::ramAddrT  clrAddr;

    // drops in the same cycle as lastOfFrame, so no sample slips in
    assign wrEn          = (phase == sifhCtrlPkg::ACCUMULATE) && !upd.lastOfFrame;
    assign upd.accepting = wrEn;
    assign inScan        = (phase == sifhCtrlPkg::SCAN);

    // phase machine
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            phase      <= sifhCtrlPkg::ACCUMULATE;
            drainCnt   <= 1'b0;
            scan.start <= 1'b0;
        end else begin
            scan.start <= 1'b0;
            case (phase)
                sifhCtrlPkg::ACCUMULATE: begin
                    if (upd.valid && upd.lastOfFrame) begin
                        phase    <= sifhCtrlPkg::DRAIN;
                        drainCnt <= 1'b0;
                    end
                end
                sifhCtrlPkg::DRAIN: begin
                    // two cycles, last write lands in the first
                    drainCnt <= 1'b1;
                    if (drainCnt) begin
                        phase      <= sifhCtrlPkg::SCAN;
                        scan.start <= 1'b1;
                    end
                end
                sifhCtrlPkg::SCAN: begin
                    if (scan.done) begin
                        phase <= sifhCtrlPkg::ACCUMULATE;
                    end
                end
                default: phase <= sifhCtrlPkg::ACCUMULATE;
            endcase
        end
    end

    // stage 1 is the read itself, this registers what was read
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            s1Valid  <= 1'b0;
            fwdValid <= 1'b0;
            clrValid <= 1'b0;
        end else begin
            s1Valid  <= upd.valid;
            fwdValid <= ramWrEn;
            clrValid <= inScan && scan.rdEn;
        end
    end

    always_ff @(posedge clk) begin
        s1Addr  <= {upd.pixel, upd.bin};
        fwdAddr <= ramWrAddr;
        fwdData <= ramWrData;
        clrAddr <= scan.addr;
    end

    // ram read saw stale data if the previous cycle wrote this bin
    assign oldCount = (fwdValid && (fwdAddr == s1Addr)) ? fwdData : ramRdData;
    // saturate at all ones
    assign incCount = (&oldCount) ? oldCount : oldCount + 1'b1;

    // port mux, scanner owns the read port during scan
    always_comb begin
        if (inScan) begin
            ramRdEn   = scan.rdEn;
            ramRdAddr = scan.addr;
            ramWrEn   = clrValid;
            ramWrAddr = clrAddr;
            ramWrData = '0;
        end else begin
            ramRdEn   = upd.valid;
            ramRdAddr = {upd.pixel, upd.bin};
            ramWrEn   = s1Valid;
            ramWrAddr = s1Addr;
            ramWrData = incCount;
        end
    end

    assign scan.rdData = ramRdData;

    sifhHistRam i_sifhHistRam (
        .clk    (clk),
        .wrEn   (ramWrEn),
        .wrAddr (ramWrAddr),
        .wrData (ramWrData),
        .rdEn   (ramRdEn),
        .rdAddr (ramRdAddr),
        .rdData (ramRdData)
    );

endmodule

// ==== design/sifhPeakScanner.sv ====
`timescale 1ns/1ps

module sifhPeakScanner (
    input  logic                    clk,
    input  logic                    rstN,
    sifhScanIf.scanner              scan,
    output logic                    peakValid,
    output sifhDataPkg::peakResultT peak
);

    sifhCtrlPkg::scanStateT state;
    sifhDataPkg::ramAddrT   addr;

    // address of the data now on rdData
    logic                   dataValid;
    sifhDataPkg::pixelT     dataPixel;
    sifhDataPkg::binT       dataBin;

    // running max of the current pixel
    sifhDataPkg::countT     maxCount;
    sifhDataPkg::binT       maxBin;
    logic                   takeNew;
    sifhDataPkg::countT     candCount;
    sifhDataPkg::binT       candBin;

    assign scan.rdEn = (state == sifhCtrlPkg::READ);
    assign scan.addr = addr;

    // bin 0 restarts the max, strictly greater keeps lowest bin on ties
    assign takeNew   = (dataBin == '0) || (scan.rdData > maxCount);
    assign candCount = takeNew ? scan.rdData : maxCount;
    assign candBin   = takeNew ? dataBin : maxBin;

    // address walk
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state     <= sifhCtrlPkg::IDLE;
            addr      <= '0;
            dataValid <= 1'b0;
            peakValid <= 1'b0;
            scan.done <= 1'b0;
        end else begin
            dataValid <= scan.rdEn;
            // emit on the pixel's last bin
            peakValid <= dataValid && (&dataBin);
            scan.done <= (state == sifhCtrlPkg::FLUSH);
            case (state)
                sifhCtrlPkg::IDLE: begin
                    if (scan.start) begin
                        state <= sifhCtrlPkg::READ;
                        addr  <= '0;
                    end
                end
                sifhCtrlPkg::READ: begin
                    addr <= addr + 1'b1;
                    if (&addr) begin
                        state <= sifhCtrlPkg::FLUSH;
                    end
                end
                // one cycle for the final read data
                sifhCtrlPkg::FLUSH: state <= sifhCtrlPkg::IDLE;
                default: state <= sifhCtrlPkg::IDLE;
            endcase
        end
    end

    // payload
    always_ff @(posedge clk) begin
        {dataPixel, dataBin} <= addr;
        if (dataValid) begin
            maxCount <= candCount;
            maxBin   <= candBin;
            peak     <= '{pixel: dataPixel, bin: candBin, count: candCount};
        end
    end

endmodule

// ==== design/sifhTop.sv ====
`timescale 1ns/1ps
`include "sifh_params.svh"

module sifhTop (
    input  logic                        clk,
    input  logic                        rstN,
    input  logic                        sampleValid,
    input  logic [`SIFH_NP-1:0]         sample,
    output logic                        wrEn,
    output logic                        peakValid,
    output logic [`SIFH_PIXEL_BITS-1:0] peakPixel,
    output logic [`SIFH_BIN_BITS-1:0]   peakBin,
    output logic [`SIFH_COUNT_BITS-1:0] peakCount
);

    sifhDataPkg::peakResultT peak;

    sifhBinUpdateIf updIf ();
    sifhScanIf      scanIf ();

    // code to bin, pixel tracking
    sifhSampleFrontEnd i_sifhSampleFrontEnd (
        .clk         (clk),
        .rstN        (rstN),
        .sampleValid (sampleValid),
        .sample      (sample),
        .upd         (updIf)
    );

    // histogram ram and rmw pipe
    sifhHistAccumulator i_sifhHistAccumulator (
        .clk  (clk),
        .rstN (rstN),
        .upd  (updIf),
        .scan (scanIf),
        .wrEn (wrEn)
    );

    // per-pixel peak search
    sifhPeakScanner i_sifhPeakScanner (
        .clk       (clk),
        .rstN      (rstN),
        .scan      (scanIf),
        .peakValid (peakValid),
        .peak      (peak)
    );

    // result struct onto flat ports
    assign peakPixel = peak.pixel;
    assign peakBin   = peak.bin;
    assign peakCount = peak.count;

endmodule

// ==== tests/sifh_checker.sv ====
`timescale 1ns/1ps
`include "sifh_params.svh"

module sifhChecker (
    input logic                        clk,
    input logic                        rstN,
    input logic                        wrEn,
    input logic                        peakValid,
    input logic [`SIFH_PIXEL_BITS-1:0] peakPixel,
    input logic [`SIFH_COUNT_BITS-1:0] peakCount
);

    // failed assertions so far
    int failCount = 0;

    // pixel of the previous result
    logic                        seenPeak;
    logic [`SIFH_PIXEL_BITS-1:0] lastPixel;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            seenPeak  <= 1'b0;
            lastPixel <= '0;
        end else if (peakValid) begin
            seenPeak  <= 1'b1;
            lastPixel <= peakPixel;
        end
    end

    // results only while sampling is stopped
    noPeakInAccumulate: assert property (@(posedge clk) disable iff (!rstN)
        peakValid |-> !wrEn)
        else begin
            $error("peakValid high while wrEn is high");
            failCount++;
        end

    // every pixel gets a full set of samples so its peak bin is never empty
    countInRange: assert property (@(posedge clk) disable iff (!rstN)
        peakValid |-> (peakCount != '0))
        else begin
            $error("peakCount is zero for a pixel with samples");
            failCount++;
        end

    // pixels in order with 3 wrapping to 0
    pixelInOrder: assert property (@(posedge clk) disable iff (!rstN)
        (peakValid && seenPeak) |-> (peakPixel == lastPixel + 1'b1))
        else begin
            $error("peakPixel did not follow the previous result");
            failCount++;
        end

    // engine takes samples right after reset
    wrEnAfterReset: assert property (@(posedge clk) $rose(rstN) |-> wrEn)
        else begin
            $error("wrEn low in the first cycle after reset");
            failCount++;
        end

endmodule

bind sifhTop sifhChecker i_sifhChecker (
    .clk       (clk),
    .rstN      (rstN),
    .wrEn      (wrEn),
    .peakValid (peakValid),
    .peakPixel (peakPixel),
    .peakCount (peakCount)
);

// ==== tests/sifhTop_tb.sv ====
`timescale 1ns/1ps
`include "sifh_params.svh"

module sifhTop_tb;

    localparam int NUM_FRAMES = 5;
    localparam int NUM_PIX    = 1 << `SIFH_PIXEL_BITS;
    localparam int NUM_BINS   = 1 << `SIFH_BIN_BITS;
    localparam int MAX_COUNT  = (1 << `SIFH_COUNT_BITS) - 1;
    localparam int LOW_BITS   = `SIFH_NP - `SIFH_BIN_BITS;
    // samples, drain, then one ram read per address
    localparam int FRAME_CYCLES   = NUM_PIX * `SIFH_ACQ_NUM + NUM_PIX * NUM_BINS + 32;
    localparam int TIMEOUT_CYCLES = NUM_FRAMES * FRAME_CYCLES + 10;

    logic                        clk;
    logic                        rstN;
    logic                        sampleValid;
    logic [`SIFH_NP-1:0]         sample;
    logic                        wrEn;
    logic                        peakValid;
    logic [`SIFH_PIXEL_BITS-1:0] peakPixel;
    logic [`SIFH_BIN_BITS-1:0]   peakBin;
    logic [`SIFH_COUNT_BITS-1:0] peakCount;

    // frame table, one column per pixel
    // dominant bin and its repeats, rest go to altBin or to random bins
    int domBin  [NUM_FRAMES][NUM_PIX] = '{'{3, 12, 21, 30}, '{7, 25, 0, 31}, '{7, 9, 18, 31},
                                          '{1, 2, 3, 4}, '{16, 5, 5, 27}};
    int domReps [NUM_FRAMES][NUM_PIX] = '{'{10, 9, 12, 8}, '{16, 8, 5, 16}, '{9, 4, 16, 6},
                                          '{2, 2, 2, 2}, '{8, 15, 1, 12}};
    int altBin  [NUM_FRAMES][NUM_PIX] = '{'{0, 0, 0, 0}, '{0, 4, 31, 0}, '{8, 9, 18, 2},
                                          '{0, 0, 0, 0}, '{15, 6, 5, 26}};
    bit noise   [NUM_FRAMES][NUM_PIX] = '{'{1, 1, 1, 1}, '{0, 0, 0, 0}, '{0, 1, 0, 0},
                                          '{1, 1, 1, 1}, '{0, 0, 0, 1}};
    // junk samples offered while wrEn is low after the frame
    bit dropAfter [NUM_FRAMES] = '{0, 1, 0, 1, 0};

    logic [31:0] rngState;
    int          errors;
    int          checked;
    // expected {pixel, bin, count} in arrival order
    logic [`SIFH_ADDR_BITS+`SIFH_COUNT_BITS-1:0] expQ [$];
    logic [`SIFH_PIXEL_BITS-1:0] expPixel;
    logic [`SIFH_BIN_BITS-1:0]   expBin;
    logic [`SIFH_COUNT_BITS-1:0] expCount;

    sifhTop i_sifhTop (
        .clk         (clk),
        .rstN        (rstN),
        .sampleValid (sampleValid),
        .sample      (sample),
        .wrEn        (wrEn),
        .peakValid   (peakValid),
        .peakPixel   (peakPixel),
        .peakBin     (peakBin),
        .peakCount   (peakCount)
    );

    always #50 clk = ~clk;

    function automatic logic [31:0] nextRandom(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // drive one frame, build the histogram, queue each pixel's peak
    task automatic runFrame(input int f);
        int hist [NUM_BINS];
        int bin;
        int bestBin;
        int bestCount;
        int cnt;
        for (int p = 0; p < NUM_PIX; p++) begin
            for (int b = 0; b < NUM_BINS; b++) begin
                hist[b] = 0;
            end
            for (int s = 0; s < `SIFH_ACQ_NUM; s++) begin
                rngState = nextRandom(rngState);
                if (s < domReps[f][p]) begin
                    bin = domBin[f][p];
                end else if (noise[f][p]) begin
                    bin = rngState[31 -: `SIFH_BIN_BITS];
                end else begin
                    bin = altBin[f][p];
                end
                // low code bits are don't-care for binning
                sampleValid = 1'b1;
                sample      = {bin[`SIFH_BIN_BITS-1:0], rngState[LOW_BITS-1:0]};
                @(negedge clk);
                hist[bin]++;
            end
            // saturate first, strict compare keeps the lowest bin on ties
            bestBin   = 0;
            bestCount = (hist[0] > MAX_COUNT) ? MAX_COUNT : hist[0];
            for (int b = 1; b < NUM_BINS; b++) begin
                cnt = (hist[b] > MAX_COUNT) ? MAX_COUNT : hist[b];
                if (cnt > bestCount) begin
                    bestBin   = b;
                    bestCount = cnt;
                end
            end
            expQ.push_back({p[`SIFH_PIXEL_BITS-1:0], bestBin[`SIFH_BIN_BITS-1:0],
                            bestCount[`SIFH_COUNT_BITS-1:0]});
        end
    endtask

    // results checked mid-cycle, in order
    always @(negedge clk) begin
        if (rstN && peakValid) begin
            if (expQ.size() == 0) begin
                $display("peakValid pulsed at %0t with no frame result pending", $time);
                errors++;
            end else begin
                {expPixel, expBin, expCount} = expQ.pop_front();
                checked++;
                if (peakPixel !== expPixel) begin
                    $display("FAIL t=%0t peakPixel: got %0d expected %0d",
                             $time, peakPixel, expPixel);
                    errors++;
                end
                if (peakBin !== expBin) begin
                    $display("FAIL t=%0t peakBin: got %0d expected %0d", $time, peakBin, expBin);
                    errors++;
                end
                if (peakCount !== expCount) begin
                    $display("FAIL t=%0t peakCount: got %0d expected %0d",
                             $time, peakCount, expCount);
                    errors++;
                end
            end
        end
    end

    initial begin
        clk         = 1'b0;
        rstN        = 1'b0;
        sampleValid = 1'b0;
        sample      = '0;
        rngState    = 32'h68aa8f1b;
        errors      = 0;
        checked     = 0;
        repeat (3) @(negedge clk);
        rstN = 1'b1;
        @(negedge clk);
        if (wrEn !== 1'b1) begin
            $display("FAIL t=%0t wrEn: got %b expected 1", $time, wrEn);
            errors++;
        end
        for (int f = 0; f < NUM_FRAMES; f++) begin
            runFrame(f);
            // drain and scan until the engine takes samples again
            while (!wrEn) begin
                rngState    = nextRandom(rngState);
                sampleValid = dropAfter[f];
                sample      = rngState[`SIFH_NP-1:0];
                @(negedge clk);
            end
            sampleValid = 1'b0;
        end
        @(negedge clk);
        if (checked != NUM_FRAMES * NUM_PIX) begin
            $display("FAIL t=%0t result count: got %0d expected %0d",
                     $time, checked, NUM_FRAMES * NUM_PIX);
            errors++;
        end
        errors += i_sifhTop.i_sifhChecker.failCount;
        $display("errors: %0d, results checked: %0d", errors, checked);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

    // watchdog
    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge clk);
        $display("timeout: %0d frames not finished after %0d cycles", NUM_FRAMES, TIMEOUT_CYCLES);
        $display("FAIL: see errors above");
        $finish;
    end

endmodule

// ==== sifhTop.f ====
+incdir+design
design/sifhCtrlPkg.sv
design/sifhDataPkg.sv
design/sifh_ifs.sv
design/sifhSampleFrontEnd.sv
design/sifhHistRam.sv
design/sifhHistAccumulator.sv
design/sifhPeakScanner.sv
design/sifhTop.sv
tests/sifh_checker.sv
tests/sifhTop_tb.sv
